// File: flist.f
+incdir+hdl
hdl/ras_pkg.sv
hdl/ras_call_decode.sv
hdl/ras_stack.sv
hdl/ras_result.sv
hdl/ras_top.sv
verification/ras_checker.sv
verification/ras_tb.sv

// File: hdl/ras_call_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "ras_params.svh"

module ras_call_decode (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  br_valid,
  input  ras_pkg::branch_info_t br,
  output logic                  ev_valid,
  output ras_pkg::ras_event_t   ev
);

  logic                   is_call;
  logic                   is_ret;
  ras_pkg::ras_op_e       op_next;
  logic [`RAS_ADDR_W-1:0] addr_next;

  // Taken jal writing the link register
  assign is_call = br.jal && (br.rd == `RAS_LINK_RD);

  // c.jr ra or jalr x0, 0(ra)
  assign is_ret = (br.instr == `RAS_RET_C_JR) || (br.instr == `RAS_RET_JALR);

  // Call rule takes priority
  always_comb begin
    op_next   = ras_pkg::op_none;
    addr_next = br.target;
    if (is_call) begin
      op_next   = ras_pkg::op_call;
      addr_next = br.next_addr;
    end else if (is_ret) begin
      op_next   = ras_pkg::op_ret;
      addr_next = br.target;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ev_valid <= 1'b0;
    end else begin
      ev_valid <= br_valid && (op_next != ras_pkg::op_none);
    end
  end

  always_ff @(posedge clk) begin
    if (br_valid) begin
      ev.op   <= op_next;
      ev.addr <= addr_next;
    end
  end

endmodule

`default_nettype wire

// File: hdl/ras_params.svh
`ifndef RAS_PARAMS_SVH
`define RAS_PARAMS_SVH

// Return address stack geometry

// Number of stack entries, power of two, at least 2
`define RAS_DEPTH 8

// Instruction address width
`define RAS_ADDR_W 32

// Hit and miss counter width
`define RAS_CNT_W 16

// Return instruction encodings
`define RAS_RET_C_JR 32'h8082
`define RAS_RET_JALR 32'h8067

// Link register used by calls
`define RAS_LINK_RD 5'd1

`endif

// File: hdl/ras_pkg.sv
`default_nettype none

`include "ras_params.svh"

package ras_pkg;

  typedef enum logic [1:0] {
    op_none,
    op_call,
    op_ret
  } ras_op_e;

  // Resolved branch as reported by the core
  typedef struct packed {
    logic [31:0]             instr;
    logic                    jal;
    logic [4:0]              rd;
    logic [`RAS_ADDR_W-1:0]  next_addr;
    logic [`RAS_ADDR_W-1:0]  target;
  } branch_info_t;

  // Next_addr for a call, target for a return
  typedef struct packed {
    ras_op_e                op;
    logic [`RAS_ADDR_W-1:0] addr;
  } ras_event_t;

  typedef struct packed {
    ras_event_t             ev;
    logic [`RAS_ADDR_W-1:0] predicted;
    logic                   had_entry;
  } ras_pop_t;

  typedef enum logic [1:0] {
    kind_call,
    kind_hit,
    kind_miss,
    kind_underflow
  } ras_kind_e;

  typedef struct packed {
    ras_kind_e              kind;
    logic [`RAS_ADDR_W-1:0] predicted;
    logic [`RAS_ADDR_W-1:0] actual;
  } ras_report_t;

  // Holds 0 up to RAS_DEPTH
  typedef logic [$clog2(`RAS_DEPTH + 1)-1:0] ras_count_t;

  typedef struct packed {
    logic       full;
    logic       empty;
    ras_count_t count;
  } ras_status_t;

endpackage

`default_nettype wire

// File: hdl/ras_result.sv
`timescale 1ns/1ps
`default_nettype none

`include "ras_params.svh"

module ras_result (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  pop_valid,
  input  ras_pkg::ras_pop_t     pop,
  output logic                  report_valid,
  output ras_pkg::ras_report_t  report,
  output logic [`RAS_CNT_W-1:0] hit_count,
  output logic [`RAS_CNT_W-1:0] miss_count
);

  ras_pkg::ras_kind_e     kind_next;
  logic [`RAS_ADDR_W-1:0] predicted_next;
  logic                   is_hit;
  logic                   is_miss;

  always_comb begin
    kind_next      = ras_pkg::kind_call;
    predicted_next = '0;
    if (pop.ev.op == ras_pkg::op_ret) begin
      predicted_next = pop.predicted;
      if (!pop.had_entry) begin
        kind_next = ras_pkg::kind_underflow;
      end else if (pop.predicted == pop.ev.addr) begin
        kind_next = ras_pkg::kind_hit;
      end else begin
        kind_next = ras_pkg::kind_miss;
      end
    end
  end

  assign is_hit  = pop_valid && (kind_next == ras_pkg::kind_hit);

  // Underflow counts as a miss
  assign is_miss = pop_valid &&
                   ((kind_next == ras_pkg::kind_miss) ||
                    (kind_next == ras_pkg::kind_underflow));

  always_ff @(posedge clk) begin
    if (reset) begin
      report_valid <= 1'b0;
    end else begin
      report_valid <= pop_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (pop_valid) begin
      report.kind      <= kind_next;
      report.predicted <= predicted_next;
      report.actual    <= pop.ev.addr;
    end
  end

  // Free-running counters, wrap on overflow
  always_ff @(posedge clk) begin
    if (reset) begin
      hit_count  <= '0;
      miss_count <= '0;
    end else begin
      if (is_hit) begin
        hit_count <= hit_count + 1'b1;
      end
      if (is_miss) begin
        miss_count <= miss_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/ras_stack.sv
`timescale 1ns/1ps
`default_nettype none

`include "ras_params.svh"

module ras_stack (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 ev_valid,
  input  ras_pkg::ras_event_t  ev,
  output logic                 pop_valid,
  output ras_pkg::ras_pop_t    pop,
  output ras_pkg::ras_status_t status
);

  localparam int PTR_W = $clog2(`RAS_DEPTH);

  logic [`RAS_ADDR_W-1:0] entries [`RAS_DEPTH];
  logic [PTR_W-1:0]       top;
  logic [PTR_W-1:0]       top_up;
  ras_pkg::ras_count_t    count;

  logic is_push;
  logic is_pop;
  logic stack_full;
  logic stack_empty;

  assign stack_full  = (count == ras_pkg::ras_count_t'(`RAS_DEPTH));
  assign stack_empty = (count == '0);

  assign is_push = ev_valid && (ev.op == ras_pkg::op_call);
  assign is_pop  = ev_valid && (ev.op == ras_pkg::op_ret) && !stack_empty;

  // Wraps onto the oldest entry when full
  assign top_up = top + 1'b1;

  always_ff @(posedge clk) begin
    if (reset) begin
      top   <= '0;
      count <= '0;
    end else if (is_push) begin
      top <= top_up;
      if (!stack_full) begin
        count <= count + 1'b1;
      end
    end else if (is_pop) begin
      top   <= top - 1'b1;
      count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (is_push) begin
      entries[top_up] <= ev.addr;
    end
  end

  // Every event goes on to the result stage, calls included
  always_ff @(posedge clk) begin
    if (reset) begin
      pop_valid <= 1'b0;
    end else begin
      pop_valid <= ev_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ev_valid) begin
      pop.ev        <= ev;
      pop.had_entry <= is_pop;
      if (is_pop) begin
        pop.predicted <= entries[top];
      end else begin
        pop.predicted <= '0;
      end
    end
  end

  always_comb begin
    status.full  = stack_full;
    status.empty = stack_empty;
    status.count = count;
  end

endmodule

`default_nettype wire

// File: hdl/ras_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ras_params.svh"

module ras_top (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  br_valid,
  input  ras_pkg::branch_info_t br,
  output logic                  report_valid,
  output ras_pkg::ras_report_t  report,
  output ras_pkg::ras_status_t  status,
  output logic [`RAS_CNT_W-1:0] hit_count,
  output logic [`RAS_CNT_W-1:0] miss_count
);

  logic                ev_valid;
  ras_pkg::ras_event_t ev;
  logic                pop_valid;
  ras_pkg::ras_pop_t   pop;

  // Branch classification
  ras_call_decode u_decode (
    .clk      (clk),
    .reset    (reset),
    .br_valid (br_valid),
    .br       (br),
    .ev_valid (ev_valid),
    .ev       (ev)
  );

  ras_stack u_stack (
    .clk       (clk),
    .reset     (reset),
    .ev_valid  (ev_valid),
    .ev        (ev),
    .pop_valid (pop_valid),
    .pop       (pop),
    .status    (status)
  );

  // Report and hit/miss counters
  ras_result u_result (
    .clk          (clk),
    .reset        (reset),
    .pop_valid    (pop_valid),
    .pop          (pop),
    .report_valid (report_valid),
    .report       (report),
    .hit_count    (hit_count),
    .miss_count   (miss_count)
  );

endmodule

`default_nettype wire

// File: verification/ras_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "ras_params.svh"

module ras_checker (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  br_valid,
  input  ras_pkg::branch_info_t br,
  input  logic                  report_valid,
  input  ras_pkg::ras_report_t  report,
  input  ras_pkg::ras_status_t  status,
  input  logic [`RAS_CNT_W-1:0] hit_count,
  input  logic [`RAS_CNT_W-1:0] miss_count,
  output int                    error_count,
  output int                    pending
);

  typedef struct packed {
    ras_pkg::ras_report_t  rep;
    logic [31:0]           due;
    logic [`RAS_CNT_W-1:0] hits;
    logic [`RAS_CNT_W-1:0] misses;
  } expect_t;

  logic [`RAS_ADDR_W-1:0] model_stk [$];
  expect_t                exp_q [$];
  int                     errors;
  logic [31:0]            cycle;
  logic [`RAS_CNT_W-1:0]  model_hits;
  logic [`RAS_CNT_W-1:0]  model_misses;
  logic [`RAS_CNT_W-1:0]  seen_hits;
  logic [`RAS_CNT_W-1:0]  seen_misses;
  // Model occupancy one and two cycles back
  int                     cnt_d1;
  int                     cnt_d2;

  initial begin
    errors      = 0;
    error_count = 0;
    pending     = 0;
  end

  // Expected report for one strobe, advances the model stack
  function automatic logic model_branch(input ras_pkg::branch_info_t b,
                                        output ras_pkg::ras_report_t r);
    logic [`RAS_ADDR_W-1:0] top_addr;
    r = '0;
    if (b.jal && (b.rd == 5'd1)) begin
      r.kind   = ras_pkg::kind_call;
      r.actual = b.next_addr;
      model_stk.push_back(b.next_addr);
      if (model_stk.size() > `RAS_DEPTH) begin
        void'(model_stk.pop_front());
      end
      return 1'b1;
    end
    if ((b.instr == 32'h8082) || (b.instr == 32'h8067)) begin
      r.actual = b.target;
      if (model_stk.size() == 0) begin
        r.kind = ras_pkg::kind_underflow;
      end else begin
        top_addr    = model_stk.pop_back();
        r.predicted = top_addr;
        r.kind      = (top_addr == b.target) ? ras_pkg::kind_hit : ras_pkg::kind_miss;
      end
      return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic compare_report();
    expect_t e;
    if (exp_q.size() == 0) begin
      $display("Unexpected report at time %0t with no call or return pending", $time);
      errors++;
      return;
    end
    e           = exp_q.pop_front();
    seen_hits   = e.hits;
    seen_misses = e.misses;
    if (e.due != cycle) begin
      $display("error at %0t: report due in cycle %0d came in cycle %0d",
               $time, e.due, cycle);
      errors++;
    end
    if (report !== e.rep) begin
      $display("error at %0t: report kind %0d pred %h act %h, expected kind %0d pred %h act %h",
               $time, report.kind, report.predicted, report.actual,
               e.rep.kind, e.rep.predicted, e.rep.actual);
      errors++;
    end
  endtask

  always @(posedge clk) begin : watch
    ras_pkg::ras_report_t rep_exp;
    ras_pkg::ras_status_t stat_exp;
    expect_t              ent;
    if (reset) begin
      model_stk.delete();
      exp_q.delete();
      cycle        = 0;
      model_hits   = '0;
      model_misses = '0;
      seen_hits    = '0;
      seen_misses  = '0;
      cnt_d1       = 0;
      cnt_d2       = 0;
    end else begin
      cycle = cycle + 1;
      if (report_valid) begin
        compare_report();
      end
      if ((hit_count !== seen_hits) || (miss_count !== seen_misses)) begin
        $display("error at %0t: hits %0d misses %0d, expected hits %0d misses %0d",
                 $time, hit_count, miss_count, seen_hits, seen_misses);
        errors++;
      end
      // Status lags the strobe by two cycles
      stat_exp.count = ras_pkg::ras_count_t'(cnt_d2);
      stat_exp.full  = (cnt_d2 == `RAS_DEPTH);
      stat_exp.empty = (cnt_d2 == 0);
      if (status !== stat_exp) begin
        $display("error at %0t: status full %b empty %b count %0d, expected %b %b %0d",
                 $time, status.full, status.empty, status.count,
                 stat_exp.full, stat_exp.empty, stat_exp.count);
        errors++;
      end
      if (br_valid && model_branch(br, rep_exp)) begin
        if (rep_exp.kind == ras_pkg::kind_hit) begin
          model_hits = model_hits + 1'b1;
        end else if (rep_exp.kind != ras_pkg::kind_call) begin
          model_misses = model_misses + 1'b1;
        end
        ent.rep    = rep_exp;
        ent.due    = cycle + 3;
        ent.hits   = model_hits;
        ent.misses = model_misses;
        exp_q.push_back(ent);
      end
      cnt_d2 = cnt_d1;
      cnt_d1 = model_stk.size();
    end
    error_count <= errors;
    pending     <= exp_q.size();
  end

endmodule

`default_nettype wire

// File: verification/ras_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ras_params.svh"

module ras_tb;

  // Limit covers 400 slots with gaps, reset and drain with margin
  localparam int MAX_CYCLES     = 2000;
  localparam int TOTAL_SLOTS    = 400;
  localparam int DIRECTED_SLOTS = 2 * `RAS_DEPTH + 8;
  localparam int RANDOM_SLOTS   = TOTAL_SLOTS - DIRECTED_SLOTS;

  logic                   clk;
  logic                   reset;
  logic                   br_valid;
  ras_pkg::branch_info_t  br;
  logic                   report_valid;
  ras_pkg::ras_report_t   report;
  ras_pkg::ras_status_t   status;
  logic [`RAS_CNT_W-1:0]  hit_count;
  logic [`RAS_CNT_W-1:0]  miss_count;
  int                     error_count;
  int                     pending;
  int                     cycles;
  integer                 seed;
  // Addresses of calls not yet returned
  logic [`RAS_ADDR_W-1:0] recent [$];

  ras_top UUT (
    .clk          (clk),
    .reset        (reset),
    .br_valid     (br_valid),
    .br           (br),
    .report_valid (report_valid),
    .report       (report),
    .status       (status),
    .hit_count    (hit_count),
    .miss_count   (miss_count)
  );

  ras_checker checker0 (
    .clk          (clk),
    .reset        (reset),
    .br_valid     (br_valid),
    .br           (br),
    .report_valid (report_valid),
    .report       (report),
    .status       (status),
    .hit_count    (hit_count),
    .miss_count   (miss_count),
    .error_count  (error_count),
    .pending      (pending)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [`RAS_ADDR_W-1:0] rand_addr();
    logic [31:0] r;
    r = $random(seed);
    return {r[31:1], 1'b0};
  endfunction

  function automatic logic coin_flip();
    logic [31:0] r;
    r = $random(seed);
    return r[0];
  endfunction

  task automatic send_branch(input ras_pkg::branch_info_t b);
    @(posedge clk);
    br_valid <= 1'b1;
    br       <= b;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    br_valid <= 1'b0;
    br       <= '0;
  endtask

  // ret_word adds a return encoding to check call priority
  task automatic do_call(input logic [`RAS_ADDR_W-1:0] addr, input logic ret_word);
    ras_pkg::branch_info_t b;
    b.instr     = ret_word ? 32'h8082 : 32'h0000_00ef;
    b.jal       = 1'b1;
    b.rd        = 5'd1;
    b.next_addr = addr;
    b.target    = rand_addr();
    recent.push_back(addr);
    if (recent.size() > `RAS_DEPTH) begin
      void'(recent.pop_front());
    end
    send_branch(b);
  endtask

  task automatic do_return(input logic use_recent);
    ras_pkg::branch_info_t b;
    logic [`RAS_ADDR_W-1:0] tgt;
    tgt = rand_addr();
    if (recent.size() > 0) begin
      if (use_recent) begin
        tgt = recent[$];
      end
      void'(recent.pop_back());
    end
    b.instr     = coin_flip() ? 32'h8082 : 32'h8067;
    b.jal       = 1'b0;
    b.rd        = 5'd0;
    b.next_addr = rand_addr();
    b.target    = tgt;
    send_branch(b);
  endtask

  task automatic do_jump();
    ras_pkg::branch_info_t b;
    b.instr     = 32'h0000_006f;
    b.jal       = coin_flip();
    b.rd        = 5'($random(seed));
    if (b.jal && (b.rd == 5'd1)) begin
      b.rd = 5'd5;
    end
    b.next_addr = rand_addr();
    b.target    = rand_addr();
    send_branch(b);
  endtask

  task automatic run_directed();
    do_return(1'b0);
    idle_cycle();
    // Overflow and unwind past the bottom
    for (int i = 0; i < `RAS_DEPTH + 2; i++) begin
      do_call(32'h0000_1000 + i * 4, 1'b0);
    end
    for (int i = 0; i < `RAS_DEPTH + 1; i++) begin
      do_return(1'b1);
    end
    idle_cycle();
    do_call(rand_addr(), 1'b0);
    do_return(1'b0);
  endtask

  task automatic run_random(input int slots);
    int pick;
    for (int i = 0; i < slots; i++) begin
      pick = {$random(seed)} % 10;
      if (pick < 4) begin
        do_call(rand_addr(), pick == 0);
      end else if (pick < 7) begin
        do_return(coin_flip());
      end else if (pick == 7) begin
        do_jump();
      end else begin
        idle_cycle();
      end
    end
  endtask

  task automatic print_summary();
    $display("Summary: %0d errors, %0d reports pending", error_count, pending);
  endtask

  initial begin
    seed     = 32'h84f1_ebab;
    reset    = 1'b1;
    br_valid = 1'b0;
    br       = '0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    run_directed();
    run_random(RANDOM_SLOTS);
    idle_cycle();
    repeat (2) @(posedge clk);
    while (pending != 0) begin
      @(posedge clk);
    end
    // Catch any report beyond the fixed latency
    repeat (4) @(posedge clk);
    @(negedge clk);
    print_summary();
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Run did not finish within %0d cycles, %0d reports still pending",
             MAX_CYCLES, pending);
    print_summary();
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
